/* hw/cpu_types_pkg.sv */
package cpu_types_pkg;

  // basic datapath widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // reset fetch address
  localparam word_t PC_INIT = 32'h0000_0000;

  // primary opcodes of the supported subset
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // function field of r-type words
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL  = 4'd0,
    ALU_SRL  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_NOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluop_t;

  // instruction word layouts
  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
    logic [4:0] shamt;
    funct_t   funct;
  } r_type_t;

  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    logic [15:0] imm;
  } i_type_t;

endpackage

/* hw/pipe_stages_pkg.sv */
package pipe_stages_pkg;

  // alu port b source, immediate flavours resolved in decode
  typedef enum logic [1:0] {
    SEL_REG  = 2'd0,
    SEL_SIMM = 2'd1,
    SEL_ZIMM = 2'd2,
    SEL_UIMM = 2'd3
  } alusrc_t;

  // destination register field
  typedef enum logic {
    SEL_RD = 1'b0,
    SEL_RT = 1'b1
  } regdst_t;

  // fetch to decode, pc_plus4 kept for branch targets later
  typedef struct packed {
    cpu_types_pkg::word_t instr;
    cpu_types_pkg::word_t pc_plus4;
  } if_id_t;

  // decode to execute
  typedef struct packed {
    cpu_types_pkg::word_t    rdat1;
    cpu_types_pkg::word_t    rdat2;
    cpu_types_pkg::word_t    imm;
    logic [4:0]              shamt;
    cpu_types_pkg::regbits_t dest;
    cpu_types_pkg::aluop_t   alu_op;
    alusrc_t                 alusrc;
    logic                    reg_wen;
    logic                    dren;
    logic                    dwen;
    logic                    halt;
  } id_ex_t;

  // execute to memory
  typedef struct packed {
    cpu_types_pkg::word_t    result;
    cpu_types_pkg::word_t    store_data;
    cpu_types_pkg::regbits_t dest;
    logic                    reg_wen;
    logic                    dren;
    logic                    dwen;
    logic                    halt;
  } ex_mem_t;

  // memory to writeback
  typedef struct packed {
    cpu_types_pkg::word_t    wdata;
    cpu_types_pkg::regbits_t dest;
    logic                    reg_wen;
    logic                    halt;
  } mem_wb_t;

endpackage

/* hw/alu.sv */
module alu (
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  input  logic [4:0]            shamt,
  input  cpu_types_pkg::aluop_t alu_op,
  output cpu_types_pkg::word_t  result,
  output logic                  zero
);

  always_comb begin
    result = '0;
    case (alu_op)
      // shifts act on rt, as in mips
      cpu_types_pkg::ALU_SLL:  result = port_b << shamt;
      cpu_types_pkg::ALU_SRL:  result = port_b >> shamt;
      cpu_types_pkg::ALU_ADD:  result = port_a + port_b;
      cpu_types_pkg::ALU_SUB:  result = port_a - port_b;
      cpu_types_pkg::ALU_AND:  result = port_a & port_b;
      cpu_types_pkg::ALU_OR:   result = port_a | port_b;
      cpu_types_pkg::ALU_XOR:  result = port_a ^ port_b;
      cpu_types_pkg::ALU_NOR:  result = ~(port_a | port_b);
      cpu_types_pkg::ALU_SLT: begin
        result = {31'd0, $signed(port_a) < $signed(port_b)};
      end
      cpu_types_pkg::ALU_SLTU: begin
        result = {31'd0, port_a < port_b};
      end
      default: result = '0;
    endcase
  end

  // for branch compares
  assign zero = (result == '0);

endmodule

/* hw/register_file.sv */
module register_file (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != '0)) begin
      regs[wsel] <= wdat;
    end
  end

  // write-through, decode sees the writeback value in the same cycle
  always_comb begin
    if (rsel1 == '0) begin
      rdat1 = '0;
    end else if (wen && (wsel == rsel1)) begin
      rdat1 = wdat;
    end else begin
      rdat1 = regs[rsel1];
    end

    if (rsel2 == '0) begin
      rdat2 = '0;
    end else if (wen && (wsel == rsel2)) begin
      rdat2 = wdat;
    end else begin
      rdat2 = regs[rsel2];
    end
  end

endmodule

/* hw/control_unit.sv */
module control_unit (
  input  cpu_types_pkg::word_t    instr,
  output cpu_types_pkg::aluop_t   alu_op,
  output pipe_stages_pkg::alusrc_t alusrc,
  output pipe_stages_pkg::regdst_t regdst,
  output logic                    reg_wen,
  output logic                    dren,
  output logic                    dwen,
  output logic                    halt,
  output logic                    uses_rs,
  output logic                    uses_rt
);

  cpu_types_pkg::r_type_t rtype;

  assign rtype = instr;

  always_comb begin
    // no-op unless a known code says otherwise
    alu_op  = cpu_types_pkg::ALU_ADD;
    alusrc  = pipe_stages_pkg::SEL_REG;
    regdst  = pipe_stages_pkg::SEL_RT;
    reg_wen = 1'b0;
    dren    = 1'b0;
    dwen    = 1'b0;
    halt    = 1'b0;
    uses_rs = 1'b0;
    uses_rt = 1'b0;

    case (rtype.opcode)
      cpu_types_pkg::RTYPE: begin
        regdst  = pipe_stages_pkg::SEL_RD;
        reg_wen = 1'b1;
        uses_rs = 1'b1;
        uses_rt = 1'b1;
        case (rtype.funct)
          cpu_types_pkg::SLL: begin
            alu_op  = cpu_types_pkg::ALU_SLL;
            uses_rs = 1'b0;
          end
          cpu_types_pkg::SRL: begin
            alu_op  = cpu_types_pkg::ALU_SRL;
            uses_rs = 1'b0;
          end
          cpu_types_pkg::ADDU: alu_op = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: alu_op = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  alu_op = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   alu_op = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::XOR:  alu_op = cpu_types_pkg::ALU_XOR;
          cpu_types_pkg::NOR:  alu_op = cpu_types_pkg::ALU_NOR;
          cpu_types_pkg::SLT:  alu_op = cpu_types_pkg::ALU_SLT;
          cpu_types_pkg::SLTU: alu_op = cpu_types_pkg::ALU_SLTU;
          default: begin
            // unknown function, drop it
            reg_wen = 1'b0;
            uses_rs = 1'b0;
            uses_rt = 1'b0;
          end
        endcase
      end
      cpu_types_pkg::ADDIU, cpu_types_pkg::SLTI: begin
        alu_op  = (rtype.opcode == cpu_types_pkg::SLTI) ? cpu_types_pkg::ALU_SLT
                                                        : cpu_types_pkg::ALU_ADD;
        alusrc  = pipe_stages_pkg::SEL_SIMM;
        reg_wen = 1'b1;
        uses_rs = 1'b1;
      end
      cpu_types_pkg::ANDI: begin
        alu_op  = cpu_types_pkg::ALU_AND;
        alusrc  = pipe_stages_pkg::SEL_ZIMM;
        reg_wen = 1'b1;
        uses_rs = 1'b1;
      end
      cpu_types_pkg::ORI: begin
        alu_op  = cpu_types_pkg::ALU_OR;
        alusrc  = pipe_stages_pkg::SEL_ZIMM;
        reg_wen = 1'b1;
        uses_rs = 1'b1;
      end
      cpu_types_pkg::XORI: begin
        alu_op  = cpu_types_pkg::ALU_XOR;
        alusrc  = pipe_stages_pkg::SEL_ZIMM;
        reg_wen = 1'b1;
        uses_rs = 1'b1;
      end
      // rs is r0 in a well formed lui, so the or passes the immediate
      cpu_types_pkg::LUI: begin
        alu_op  = cpu_types_pkg::ALU_OR;
        alusrc  = pipe_stages_pkg::SEL_UIMM;
        reg_wen = 1'b1;
      end
      cpu_types_pkg::LW: begin
        alusrc  = pipe_stages_pkg::SEL_SIMM;
        reg_wen = 1'b1;
        dren    = 1'b1;
        uses_rs = 1'b1;
      end
      cpu_types_pkg::SW: begin
        alusrc  = pipe_stages_pkg::SEL_SIMM;
        dwen    = 1'b1;
        uses_rs = 1'b1;
        uses_rt = 1'b1;
      end
      cpu_types_pkg::HALT: halt = 1'b1;
      default: halt = 1'b0;
    endcase
  end

endmodule

/* hw/pipe_reg.sv */
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     enable,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // all-zero payload is a bubble
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (enable) begin
      q <= d;
    end
  end

endmodule

/* hw/hazard_unit.sv */
module hazard_unit (
  input  cpu_types_pkg::regbits_t rs,
  input  cpu_types_pkg::regbits_t rt,
  input  logic                    uses_rs,
  input  logic                    uses_rt,
  input  cpu_types_pkg::regbits_t ex_dest,
  input  logic                    ex_wen,
  input  cpu_types_pkg::regbits_t mem_dest,
  input  logic                    mem_wen,
  input  logic                    halted,
  output logic                    stall,
  output logic                    bubble
);

  logic rs_hit;
  logic rt_hit;

  // writeback needs no check, the register file writes through
  always_comb begin
    rs_hit = 1'b0;
    rt_hit = 1'b0;
    if (uses_rs && (rs != '0)) begin
      rs_hit = (ex_wen && (ex_dest == rs)) || (mem_wen && (mem_dest == rs));
    end
    if (uses_rt && (rt != '0)) begin
      rt_hit = (ex_wen && (ex_dest == rt)) || (mem_wen && (mem_dest == rt));
    end
  end

  // halted holds fetch and keeps feeding bubbles
  assign stall  = halted || rs_hit || rt_hit;
  assign bubble = stall;

endmodule

/* hw/datapath.sv */
module datapath (
  input  logic                 CLK,
  input  logic                 rst_n,
  output cpu_types_pkg::word_t imemaddr,
  input  cpu_types_pkg::word_t imemload,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 dmemren,
  output logic                 dmemwen,
  input  cpu_types_pkg::word_t dmemload,
  output logic                 halt
);

  cpu_types_pkg::word_t     pc;
  pipe_stages_pkg::if_id_t  if_id_d, if_id_q;
  pipe_stages_pkg::id_ex_t  id_ex_d, id_ex_q;
  pipe_stages_pkg::ex_mem_t ex_mem_d, ex_mem_q;
  pipe_stages_pkg::mem_wb_t mem_wb_d, mem_wb_q;

  // decode stage
  cpu_types_pkg::i_type_t   itype;
  cpu_types_pkg::r_type_t   rtype;
  cpu_types_pkg::aluop_t    cu_alu_op;
  pipe_stages_pkg::alusrc_t cu_alusrc;
  pipe_stages_pkg::regdst_t cu_regdst;
  logic                     cu_reg_wen, cu_dren, cu_dwen, cu_halt;
  logic                     uses_rs, uses_rt;
  cpu_types_pkg::word_t     rdat1, rdat2, imm_ext;
  cpu_types_pkg::regbits_t  dest;
  logic                     stall, bubble, halted;

  // execute stage
  cpu_types_pkg::word_t     port_b, alu_result;

  // fetch
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pc <= cpu_types_pkg::PC_INIT;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  assign imemaddr         = pc;
  assign if_id_d.instr    = imemload;
  assign if_id_d.pc_plus4 = pc + 32'd4;

  pipe_reg #(.payload_t(pipe_stages_pkg::if_id_t)) if_id (
    .CLK(CLK), .rst_n(rst_n), .enable(!stall), .flush(1'b0), .d(if_id_d), .q(if_id_q)
  );

  // decode
  assign itype = if_id_q.instr;
  assign rtype = if_id_q.instr;

  control_unit i_control_unit (
    .instr(if_id_q.instr), .alu_op(cu_alu_op), .alusrc(cu_alusrc), .regdst(cu_regdst),
    .reg_wen(cu_reg_wen), .dren(cu_dren), .dwen(cu_dwen), .halt(cu_halt),
    .uses_rs(uses_rs), .uses_rt(uses_rt)
  );

  register_file i_register_file (
    .CLK(CLK), .rst_n(rst_n), .wen(mem_wb_q.reg_wen), .wsel(mem_wb_q.dest),
    .wdat(mem_wb_q.wdata), .rsel1(itype.rs), .rsel2(itype.rt), .rdat1(rdat1), .rdat2(rdat2)
  );

  // immediate extender
  always_comb begin
    case (cu_alusrc)
      pipe_stages_pkg::SEL_ZIMM: imm_ext = {16'h0000, itype.imm};
      pipe_stages_pkg::SEL_UIMM: imm_ext = {itype.imm, 16'h0000};
      default:                   imm_ext = {{16{itype.imm[15]}}, itype.imm};
    endcase
  end

  // write-select mux, resolved early so the hazard unit can compare it
  always_comb begin
    case (cu_regdst)
      pipe_stages_pkg::SEL_RD: dest = rtype.rd;
      default:                 dest = itype.rt;
    endcase
  end

  // a halt in writeback counts as halted already
  assign halted = halt || mem_wb_q.halt;

  hazard_unit i_hazard_unit (
    .rs(itype.rs), .rt(itype.rt), .uses_rs(uses_rs), .uses_rt(uses_rt),
    .ex_dest(id_ex_q.dest), .ex_wen(id_ex_q.reg_wen),
    .mem_dest(ex_mem_q.dest), .mem_wen(ex_mem_q.reg_wen),
    .halted(halted), .stall(stall), .bubble(bubble)
  );

  assign id_ex_d.rdat1   = rdat1;
  assign id_ex_d.rdat2   = rdat2;
  assign id_ex_d.imm     = imm_ext;
  assign id_ex_d.shamt   = rtype.shamt;
  assign id_ex_d.dest    = dest;
  assign id_ex_d.alu_op  = cu_alu_op;
  assign id_ex_d.alusrc  = cu_alusrc;
  assign id_ex_d.reg_wen = cu_reg_wen;
  assign id_ex_d.dren    = cu_dren;
  assign id_ex_d.dwen    = cu_dwen;
  assign id_ex_d.halt    = cu_halt;

  pipe_reg #(.payload_t(pipe_stages_pkg::id_ex_t)) id_ex (
    .CLK(CLK), .rst_n(rst_n), .enable(1'b1), .flush(bubble), .d(id_ex_d), .q(id_ex_q)
  );

  // execute
  assign port_b = (id_ex_q.alusrc == pipe_stages_pkg::SEL_REG) ? id_ex_q.rdat2 : id_ex_q.imm;

  alu i_alu (
    .port_a(id_ex_q.rdat1), .port_b(port_b), .shamt(id_ex_q.shamt),
    .alu_op(id_ex_q.alu_op), .result(alu_result), .zero()
  );

  assign ex_mem_d.result     = alu_result;
  assign ex_mem_d.store_data = id_ex_q.rdat2;
  assign ex_mem_d.dest       = id_ex_q.dest;
  assign ex_mem_d.reg_wen    = id_ex_q.reg_wen;
  assign ex_mem_d.dren       = id_ex_q.dren;
  assign ex_mem_d.dwen       = id_ex_q.dwen;
  assign ex_mem_d.halt       = id_ex_q.halt;

  pipe_reg #(.payload_t(pipe_stages_pkg::ex_mem_t)) ex_mem (
    .CLK(CLK), .rst_n(rst_n), .enable(1'b1), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
  );

  // memory, strobes die once an older halt has reached writeback
  assign dmemaddr  = ex_mem_q.result;
  assign dmemstore = ex_mem_q.store_data;
  assign dmemren   = ex_mem_q.dren && !halted;
  assign dmemwen   = ex_mem_q.dwen && !halted;

  // writeback data select
  assign mem_wb_d.wdata   = ex_mem_q.dren ? dmemload : ex_mem_q.result;
  assign mem_wb_d.dest    = ex_mem_q.dest;
  assign mem_wb_d.reg_wen = ex_mem_q.reg_wen;
  assign mem_wb_d.halt    = ex_mem_q.halt;

  pipe_reg #(.payload_t(pipe_stages_pkg::mem_wb_t)) mem_wb (
    .CLK(CLK), .rst_n(rst_n), .enable(1'b1), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
  );

  // sticky halt
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      halt <= 1'b0;
    end else if (mem_wb_q.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

/* sim/datapath_assert.sv */
module datapath_assert (
  input logic                 CLK,
  input logic                 rst_n,
  input cpu_types_pkg::word_t imemaddr,
  input logic                 dmemren,
  input logic                 dmemwen,
  input logic                 halt
);

  int failures = 0;

  // a load and a store never share the memory stage
  strobes_exclusive: assert property (
    @(posedge CLK) disable iff (!rst_n) !(dmemren && dmemwen)
  ) else begin
    $error("dmemren and dmemwen high in the same cycle");
    failures++;
  end

  reset_idle: assert property (
    @(posedge CLK) !rst_n |-> (!dmemren && !dmemwen && !halt &&
                               imemaddr == cpu_types_pkg::PC_INIT)
  ) else begin
    $error("outputs not idle during reset");
    failures++;
  end

  halt_sticky: assert property (
    @(posedge CLK) disable iff (!rst_n) halt |=> halt
  ) else begin
    $error("halt dropped without reset");
    failures++;
  end

  halt_quiet: assert property (
    @(posedge CLK) disable iff (!rst_n) halt |-> (!dmemren && !dmemwen)
  ) else begin
    $error("memory strobe after halt");
    failures++;
  end

  halt_frozen: assert property (
    @(posedge CLK) disable iff (!rst_n) halt |=> $stable(imemaddr)
  ) else begin
    $error("imemaddr moved after halt");
    failures++;
  end

  // no branches, so the fetch address only steps or holds
  fetch_step: assert property (
    @(posedge CLK) disable iff (!rst_n)
      1'b1 |=> (imemaddr == $past(imemaddr) || imemaddr == $past(imemaddr) + 32'd4)
  ) else begin
    $error("imemaddr neither held nor advanced by 4");
    failures++;
  end

endmodule

/* sim/datapath_tb.sv */
module datapath_tb;

  localparam int DRIVE_DELAY   = 2;
  localparam int WAIT_LIMIT    = 400;
  localparam int SETTLE_CYCLES = 6;

  logic                 CLK;
  logic                 rst_n;
  cpu_types_pkg::word_t imemaddr;
  cpu_types_pkg::word_t imemload;
  cpu_types_pkg::word_t dmemaddr;
  cpu_types_pkg::word_t dmemstore;
  cpu_types_pkg::word_t dmemload;
  logic                 dmemren;
  logic                 dmemwen;
  logic                 halt;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] prog [$];
  logic [31:0] store_addr [$];
  logic [31:0] store_data [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] lfsr_state;
  string       test_name;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          assert_seen;

  cpu_types_pkg::funct_t rops [10] = '{
    cpu_types_pkg::SLL, cpu_types_pkg::SRL, cpu_types_pkg::ADDU, cpu_types_pkg::SUBU,
    cpu_types_pkg::AND, cpu_types_pkg::OR, cpu_types_pkg::XOR, cpu_types_pkg::NOR,
    cpu_types_pkg::SLT, cpu_types_pkg::SLTU
  };

  datapath i_dut (
    .CLK(CLK), .rst_n(rst_n), .imemaddr(imemaddr), .imemload(imemload),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dmemren(dmemren), .dmemwen(dmemwen),
    .dmemload(dmemload), .halt(halt)
  );

  bind datapath datapath_assert i_assert (
    .CLK(CLK), .rst_n(rst_n), .imemaddr(imemaddr), .dmemren(dmemren),
    .dmemwen(dmemwen), .halt(halt)
  );

  // both memories answer combinationally
  assign imemload = imem[imemaddr[9:2]];
  // load data only while the read strobe is up
  assign dmemload = dmemren ? dmem[dmemaddr[9:2]] : 32'h0;

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // data memory, stores taken mid-cycle where the strobe is stable
  initial begin
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'h0;
    end
    forever begin
      @(negedge CLK);
      if (!rst_n) begin
        for (int i = 0; i < 256; i++) begin
          dmem[i] = 32'h0;
        end
        store_addr.delete();
        store_data.delete();
      end else if (dmemwen) begin
        store_addr.push_back(dmemaddr);
        store_data.push_back(dmemstore);
        dmem[dmemaddr[9:2]] = dmemstore;
      end
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = 32'h0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] rtype_word(input cpu_types_pkg::funct_t f, input int rd,
                                             input int rs, input int rt, input int sh);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], f};
  endfunction

  function automatic logic [31:0] itype_word(input cpu_types_pkg::opcode_t op, input int rt,
                                             input int rs, input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  // reference semantics of the r-type subset
  function automatic logic [31:0] model_rtype(input cpu_types_pkg::funct_t f,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [4:0] sh);
    case (f)
      cpu_types_pkg::SLL:  return b << sh;
      cpu_types_pkg::SRL:  return b >> sh;
      cpu_types_pkg::ADDU: return a + b;
      cpu_types_pkg::SUBU: return a - b;
      cpu_types_pkg::AND:  return a & b;
      cpu_types_pkg::OR:   return a | b;
      cpu_types_pkg::XOR:  return a ^ b;
      cpu_types_pkg::NOR:  return ~(a | b);
      cpu_types_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cpu_types_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:             return 32'd0;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic load_const(input int rt, input logic [31:0] value);
    emit(itype_word(cpu_types_pkg::LUI, rt, 0, value >> 16));
    emit(itype_word(cpu_types_pkg::ORI, rt, rt, value & 32'h0000_ffff));
  endtask

  task automatic store_reg(input int rt, input int addr, input logic [31:0] expected);
    emit(itype_word(cpu_types_pkg::SW, rt, 0, addr));
    exp_addr.push_back(addr);
    exp_data.push_back(expected);
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  // reset for 4 cycles with the program loaded, then check the idle state
  task automatic start_program();
    @(posedge CLK);
    #DRIVE_DELAY;
    rst_n = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
    end
    @(negedge CLK);
    check_value("halt in reset", 32'd0, 32'(halt));
    check_value("dmemren in reset", 32'd0, 32'(dmemren));
    check_value("dmemwen in reset", 32'd0, 32'(dmemwen));
    check_value("imemaddr in reset", cpu_types_pkg::PC_INIT, imemaddr);
    repeat (4) @(posedge CLK);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    @(negedge CLK);
    check_value("first fetch address", cpu_types_pkg::PC_INIT, imemaddr);
  endtask

  task automatic wait_for_store();
    int cycles;
    cycles = 0;
    while (!dmemwen && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!dmemwen) begin
      $display("%s: no store strobe within %0d cycles", test_name, WAIT_LIMIT);
      test_errors++;
    end
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!halt && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!halt) begin
      $display("%s: halt did not rise within %0d cycles", test_name, WAIT_LIMIT);
      test_errors++;
    end
  endtask

  task automatic settle_after_halt();
    logic [31:0] frozen;
    frozen = imemaddr;
    repeat (SETTLE_CYCLES) @(negedge CLK);
    check_value("imemaddr after halt", frozen, imemaddr);
    check_value("halt after halt", 32'd1, 32'(halt));
  endtask

  task automatic check_stores();
    if (store_addr.size() != exp_addr.size()) begin
      $display("%s: expected %0d stores, saw %0d", test_name, exp_addr.size(),
               store_addr.size());
      test_errors++;
    end
    for (int i = 0; i < store_addr.size() && i < exp_addr.size(); i++) begin
      check_value($sformatf("store %0d address", i), exp_addr[i], store_addr[i]);
      check_value($sformatf("store %0d data", i), exp_data[i], store_data[i]);
    end
  endtask

  task automatic finish_test();
    int fresh;
    fresh = i_dut.i_assert.failures - assert_seen;
    assert_seen = i_dut.i_assert.failures;
    if (fresh != 0) begin
      $display("%s: protocol assertions failed %0d times", test_name, fresh);
      test_errors += fresh;
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: passed", test_name);
    end else begin
      $display("test %s: failed with %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  task automatic run_test();
    emit({cpu_types_pkg::HALT, 26'd0});
    start_program();
    wait_for_halt();
    settle_after_halt();
    check_stores();
    finish_test();
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sh;
    logic [31:0] imm;
    logic [31:0] sext;
    logic [31:0] zext;
    rst_n = 1'b1;
    lfsr_state = 32'hd20f_72f7;
    tests_run = 0;
    tests_failed = 0;
    assert_seen = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0;
    end
    #1;
    rst_n = 1'b0;

    begin_test("rtype");
    a = random_bits(32);
    // opposite signs so slt and sltu disagree
    b = random_bits(31);
    b[31] = ~a[31];
    load_const(1, a);
    load_const(2, b);
    for (int k = 0; k < 10; k++) begin
      sh = random_bits(5);
      emit(rtype_word(rops[k], 3 + k, 1, 2, sh));
      store_reg(3 + k, 4 * k, model_rtype(rops[k], a, b, sh[4:0]));
    end
    run_test();

    // bit 15 set so sign and zero extension differ
    begin_test("immediate");
    a = random_bits(32);
    imm = random_bits(16) | 32'h0000_8000;
    sext = {{16{imm[15]}}, imm[15:0]};
    zext = {16'h0000, imm[15:0]};
    load_const(1, a);
    emit(itype_word(cpu_types_pkg::ADDIU, 2, 1, imm));
    // slti against r0, the extension decides the outcome
    emit(itype_word(cpu_types_pkg::SLTI, 3, 0, imm));
    emit(itype_word(cpu_types_pkg::ANDI, 4, 1, imm));
    emit(itype_word(cpu_types_pkg::ORI, 5, 1, imm));
    emit(itype_word(cpu_types_pkg::XORI, 6, 1, imm));
    emit(itype_word(cpu_types_pkg::LUI, 7, 0, imm));
    store_reg(2, 0, a + sext);
    store_reg(3, 4, ($signed(32'd0) < $signed(sext)) ? 32'd1 : 32'd0);
    store_reg(4, 8, a & zext);
    store_reg(5, 12, a | zext);
    store_reg(6, 16, a ^ zext);
    store_reg(7, 20, {imm[15:0], 16'h0000});
    run_test();

    // consumers at distance 1, 2 and 3
    begin_test("dependence");
    a = random_bits(32);
    b = random_bits(32);
    load_const(1, a);
    load_const(2, b);
    emit(rtype_word(cpu_types_pkg::ADDU, 3, 1, 2, 0));
    emit(rtype_word(cpu_types_pkg::ADDU, 4, 3, 1, 0));
    emit(32'h0);
    emit(rtype_word(cpu_types_pkg::SUBU, 5, 1, 4, 0));
    emit(32'h0);
    emit(32'h0);
    emit(rtype_word(cpu_types_pkg::XOR, 6, 5, 2, 0));
    store_reg(3, 0, a + b);
    store_reg(4, 4, a + b + a);
    store_reg(5, 8, a - (a + b + a));
    store_reg(6, 12, (a - (a + b + a)) ^ b);
    run_test();

    begin_test("load_store");
    a = random_bits(32);
    load_const(1, a);
    store_reg(1, 64, a);
    emit(itype_word(cpu_types_pkg::LW, 2, 0, 64));
    emit(rtype_word(cpu_types_pkg::ADDU, 3, 2, 2, 0));
    store_reg(3, 68, a + a);
    emit(itype_word(cpu_types_pkg::ORI, 4, 0, 64));
    emit(itype_word(cpu_types_pkg::LW, 5, 4, 4));
    store_reg(5, 72, a + a);
    run_test();

    // stores behind the halt must never reach memory
    begin_test("halt");
    a = random_bits(32);
    load_const(1, a);
    store_reg(1, 0, a);
    emit({cpu_types_pkg::HALT, 26'd0});
    emit(itype_word(cpu_types_pkg::SW, 1, 0, 4));
    emit(itype_word(cpu_types_pkg::SW, 1, 0, 8));
    emit(itype_word(cpu_types_pkg::SW, 1, 0, 12));
    run_test();

    // reset lands while stores are in flight
    begin_test("reset");
    a = random_bits(32);
    load_const(1, a);
    for (int k = 0; k < 4; k++) begin
      store_reg(1, 16 * k, a);
    end
    start_program();
    wait_for_store();
    run_test();

    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* filelist.f */
hw/cpu_types_pkg.sv
hw/pipe_stages_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/control_unit.sv
hw/pipe_reg.sv
hw/hazard_unit.sv
hw/datapath.sv
sim/datapath_assert.sv
sim/datapath_tb.sv
